// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_exec_core
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: alu_exec.sv
/* ALU, result register, register file writeback and branch resolution */

`timescale 1ns/1ps

module alu_exec #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  arst_n,
    alu_req_if.dst                req,
    input  logic [4:0]            rd_addr,
    input  logic                  rd_we,
    input  riscv_pkg::br_kind_t   br_kind,
    input  logic                  br_invert,
    output logic [data_width-1:0] result,
    output logic [4:0]            result_rd,
    output logic                  result_valid,
    output logic                  branch_taken,
    output logic                  wr_en,
    output logic [4:0]            wr_addr,
    output logic [data_width-1:0] wr_data
);

    localparam int shamt_w = $clog2(data_width);

    logic [data_width-1:0] alu_out;
    logic [shamt_w-1:0]    shamt;
    logic                  taken;

    assign shamt = req.op2[shamt_w-1:0];

    always_comb begin
        alu_out = '0;
        case (req.alu_sel)
            riscv_pkg::ALU_ADD:  alu_out = req.op1 + req.op2;
            riscv_pkg::ALU_SLL:  alu_out = req.op1 << shamt;
            riscv_pkg::ALU_SLT:  alu_out[0] = $signed(req.op1) < $signed(req.op2);
            riscv_pkg::ALU_SLTU: alu_out[0] = req.op1 < req.op2;
            riscv_pkg::ALU_XOR:  alu_out = req.op1 ^ req.op2;
            riscv_pkg::ALU_SRL:  alu_out = req.op1 >> shamt;
            riscv_pkg::ALU_SRA:  alu_out = $unsigned($signed(req.op1) >>> shamt);
            riscv_pkg::ALU_OR:   alu_out = req.op1 | req.op2;
            riscv_pkg::ALU_AND:  alu_out = req.op1 & req.op2;
            riscv_pkg::ALU_LUI:  alu_out = req.op1 << 12;
            riscv_pkg::ALU_NONE: alu_out = '0;
            default:             alu_out = '0;
        endcase
    end

    // XOR result is zero on equal, SLT/SLTU give one on less-than
    always_comb begin
        case (br_kind)
            riscv_pkg::BR_ZERO: taken = (alu_out == '0) ^ br_invert;
            riscv_pkg::BR_ONE:  taken = (alu_out == data_width'(1)) ^ br_invert;
            default:            taken = 1'b0;
        endcase
    end

    // Write lands on the same edge that captures the result
    assign wr_en   = req.valid && rd_we && (rd_addr != 5'd0);
    assign wr_addr = rd_addr;
    assign wr_data = alu_out;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result       <= '0;
            result_rd    <= '0;
            result_valid <= 1'b0;
            branch_taken <= 1'b0;
        end else begin
            result_valid <= req.valid;
            if (req.valid) begin
                result       <= alu_out;
                result_rd    <= rd_addr;
                branch_taken <= taken;
            end
        end
    end

endmodule

// File: alu_req_if.sv
/* Decoder to ALU stage request interface */

`timescale 1ns/1ps

interface alu_req_if #(
    parameter int data_width = 32
);

    logic [data_width-1:0] op1;
    logic [data_width-1:0] op2;
    riscv_pkg::alu_sel_t   alu_sel;
    // Plain strobe, no back-pressure
    logic                  valid;

    modport src (
        output op1,
        output op2,
        output alu_sel,
        output valid
    );

    modport dst (
        input op1,
        input op2,
        input alu_sel,
        input valid
    );

endinterface

// File: decode_alu.sv
/* ALU operand and function decoder
   Picks op1, op2 and the ALU select from the instruction */

`timescale 1ns/1ps

module decode_alu #(
    parameter int data_width = 32
) (
    input  logic [31:0]           inst,
    input  logic                  inst_valid,
    input  logic [data_width-1:0] rs1_data,
    input  logic [data_width-1:0] rs2_data,
    alu_req_if.src                req
);

    // Instruction fields
    riscv_pkg::opcode_t opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [4:0]         shamt;
    logic [11:0]        imm12;
    logic [11:0]        split_imm12;
    logic [19:0]        lui_imm;

    // Extended immediates
    logic [data_width-1:0] sext_imm;
    logic [data_width-1:0] sext_split_imm;

    assign opcode      = riscv_pkg::opcode_t'(inst[6:0]);
    assign funct3      = inst[14:12];
    assign funct7      = inst[31:25];
    assign shamt       = inst[24:20];
    assign imm12       = inst[31:20];
    assign split_imm12 = {inst[31:25], inst[11:7]};
    assign lui_imm     = inst[31:12];

    assign sext_imm       = {{(data_width-12){imm12[11]}}, imm12};
    assign sext_split_imm = {{(data_width-12){split_imm12[11]}}, split_imm12};

    assign req.valid = inst_valid;

    // LUI immediate goes in low bits, the ALU moves it up by 12
    assign req.op1 = (opcode == riscv_pkg::OPCODE_LUI) ?
                     {{(data_width-20){1'b0}}, lui_imm} : rs1_data;

    always_comb begin
        case (opcode)
            riscv_pkg::OPCODE_OP: begin
                // SUB is ADD with funct7 bit 5 set
                if (funct3 == riscv_pkg::F3_ADD && funct7[5]) begin
                    req.op2 = -rs2_data;
                end else begin
                    req.op2 = rs2_data;
                end
            end
            riscv_pkg::OPCODE_OP_IMM: begin
                if (funct3 == riscv_pkg::F3_SLL || funct3 == riscv_pkg::F3_SR) begin
                    req.op2 = {{(data_width-5){1'b0}}, shamt};
                end else begin
                    req.op2 = sext_imm;
                end
            end
            riscv_pkg::OPCODE_STORE: req.op2 = sext_split_imm;
            riscv_pkg::OPCODE_LOAD:  req.op2 = sext_imm;
            // Branches compare against rs2
            default:                 req.op2 = rs2_data;
        endcase
    end

    always_comb begin
        case (opcode)
            riscv_pkg::OPCODE_OP, riscv_pkg::OPCODE_OP_IMM: begin
                case (funct3)
                    riscv_pkg::F3_ADD:  req.alu_sel = riscv_pkg::ALU_ADD;
                    riscv_pkg::F3_SLL:  req.alu_sel = riscv_pkg::ALU_SLL;
                    riscv_pkg::F3_SLT:  req.alu_sel = riscv_pkg::ALU_SLT;
                    riscv_pkg::F3_SLTU: req.alu_sel = riscv_pkg::ALU_SLTU;
                    riscv_pkg::F3_XOR:  req.alu_sel = riscv_pkg::ALU_XOR;
                    riscv_pkg::F3_SR: begin
                        req.alu_sel = inst[30] ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
                    end
                    riscv_pkg::F3_OR:   req.alu_sel = riscv_pkg::ALU_OR;
                    default:            req.alu_sel = riscv_pkg::ALU_AND;
                endcase
            end
            riscv_pkg::OPCODE_LOAD, riscv_pkg::OPCODE_STORE: begin
                req.alu_sel = riscv_pkg::ALU_ADD;
            end
            riscv_pkg::OPCODE_LUI: req.alu_sel = riscv_pkg::ALU_LUI;
            riscv_pkg::OPCODE_BRANCH: begin
                case (funct3)
                    riscv_pkg::F3_BEQ, riscv_pkg::F3_BNE: begin
                        req.alu_sel = riscv_pkg::ALU_XOR;
                    end
                    riscv_pkg::F3_BLT, riscv_pkg::F3_BGE: begin
                        req.alu_sel = riscv_pkg::ALU_SLT;
                    end
                    riscv_pkg::F3_BLTU, riscv_pkg::F3_BGEU: begin
                        req.alu_sel = riscv_pkg::ALU_SLTU;
                    end
                    default: req.alu_sel = riscv_pkg::ALU_NONE;
                endcase
            end
            default: req.alu_sel = riscv_pkg::ALU_NONE;
        endcase
    end

endmodule

// File: decode_ctrl.sv
/* Destination, writeback enable and branch kind decoder */

`timescale 1ns/1ps

module decode_ctrl (
    input  logic [31:0]         inst,
    output logic [4:0]          rd_addr,
    output logic                rd_we,
    output riscv_pkg::br_kind_t br_kind,
    output logic                br_invert
);

    riscv_pkg::opcode_t opcode;
    logic [2:0]         funct3;

    assign opcode  = riscv_pkg::opcode_t'(inst[6:0]);
    assign funct3  = inst[14:12];
    assign rd_addr = inst[11:7];

    // Loads still claim rd even without a data memory
    always_comb begin
        case (opcode)
            riscv_pkg::OPCODE_OP,
            riscv_pkg::OPCODE_OP_IMM,
            riscv_pkg::OPCODE_LUI,
            riscv_pkg::OPCODE_LOAD: rd_we = 1'b1;
            default:                rd_we = 1'b0;
        endcase
    end

    always_comb begin
        br_kind   = riscv_pkg::BR_NONE;
        br_invert = 1'b0;
        if (opcode == riscv_pkg::OPCODE_BRANCH) begin
            case (funct3)
                riscv_pkg::F3_BEQ, riscv_pkg::F3_BNE: begin
                    br_kind = riscv_pkg::BR_ZERO;
                end
                riscv_pkg::F3_BLT, riscv_pkg::F3_BGE,
                riscv_pkg::F3_BLTU, riscv_pkg::F3_BGEU: begin
                    br_kind = riscv_pkg::BR_ONE;
                end
                default: br_kind = riscv_pkg::BR_NONE;
            endcase
            // Negated forms
            br_invert = (funct3 == riscv_pkg::F3_BNE) ||
                        (funct3 == riscv_pkg::F3_BGE) ||
                        (funct3 == riscv_pkg::F3_BGEU);
        end
    end

endmodule

// File: exec_core.sv
/* Execute slice top level
   Register file, both decoders and the ALU stage */

`timescale 1ns/1ps

module exec_core #(
    parameter int data_width = riscv_pkg::xlen
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [31:0]           inst,
    input  logic                  inst_valid,
    output logic [data_width-1:0] result,
    output logic [4:0]            result_rd,
    output logic                  result_valid,
    output logic                  branch_taken
);

    logic [data_width-1:0] rs1_data;
    logic [data_width-1:0] rs2_data;
    logic [4:0]            rd_addr;
    logic                  rd_we;
    riscv_pkg::br_kind_t   br_kind;
    logic                  br_invert;
    logic                  wr_en;
    logic [4:0]            wr_addr;
    logic [data_width-1:0] wr_data;

    alu_req_if #(.data_width(data_width)) alu_req ();

    regfile #(.data_width(data_width)) regfile_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (inst[19:15]),
        .rs2_addr (inst[24:20]),
        .wr_addr  (wr_addr),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    decode_alu #(.data_width(data_width)) decode_alu_inst (
        .inst       (inst),
        .inst_valid (inst_valid),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .req        (alu_req.src)
    );

    decode_ctrl decode_ctrl_inst (
        .inst      (inst),
        .rd_addr   (rd_addr),
        .rd_we     (rd_we),
        .br_kind   (br_kind),
        .br_invert (br_invert)
    );

    alu_exec #(.data_width(data_width)) alu_exec_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (alu_req.dst),
        .rd_addr      (rd_addr),
        .rd_we        (rd_we),
        .br_kind      (br_kind),
        .br_invert    (br_invert),
        .result       (result),
        .result_rd    (result_rd),
        .result_valid (result_valid),
        .branch_taken (branch_taken),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

endmodule

// File: exec_core_checker.sv
/* Concurrent assertions on the ALU stage handshake and reset */

`timescale 1ns/1ps

module exec_core_checker (
    input logic clk,
    input logic arst_n,
    input logic valid,
    input logic result_valid,
    input logic branch_taken
);

    // One-cycle pulse after each valid
    a_pulse_after_valid: assert property (@(posedge clk) disable iff (!arst_n)
        valid |=> result_valid)
        else $error("result_valid missing one cycle after valid");

    a_no_stray_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        !valid |=> !result_valid)
        else $error("result_valid high without valid in the cycle before");

    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !result_valid && !branch_taken)
        else $error("result_valid or branch_taken high during reset");

endmodule

bind alu_exec exec_core_checker exec_core_checker_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .valid        (req.valid),
    .result_valid (result_valid),
    .branch_taken (branch_taken)
);

// File: flist.f
riscv_pkg.sv
alu_req_if.sv
regfile.sv
decode_alu.sv
decode_ctrl.sv
alu_exec.sv
exec_core.sv
exec_core_checker.sv
tb_exec_core.sv

// File: regfile.sv
/* 32-entry integer register file, two read ports and one write port */

`timescale 1ns/1ps

module regfile #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [4:0]            rs1_addr,
    input  logic [4:0]            rs2_addr,
    input  logic [4:0]            wr_addr,
    input  logic                  wr_en,
    input  logic [data_width-1:0] wr_data,
    output logic [data_width-1:0] rs1_data,
    output logic [data_width-1:0] rs2_data
);

    // x0 has no storage
    logic [data_width-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational reads, x0 is hardwired zero
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: riscv_pkg.sv
/* Shared RV32I definitions for the execute slice
   Data width, opcodes, funct3 codes, ALU select and branch kind */

package riscv_pkg;

    // One machine word
    localparam int xlen = 32;

    // Major opcodes handled by the slice
    typedef enum logic [6:0] {
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_BRANCH = 7'b1100011
    } opcode_t;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ALU function select
    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_LUI  = 4'd10
    } alu_sel_t;

    // How a branch tests the ALU result
    // BR_ZERO means taken on a zero result, BR_ONE on a result of one
    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_ZERO = 2'd1,
        BR_ONE  = 2'd2
    } br_kind_t;

endpackage

// File: tb_exec_core.sv
/* Directed testbench for the execute slice
   Shadow register model, compare tasks and a watchdog */

`timescale 1ns/1ps

module tb_exec_core;

    localparam int xlen = riscv_pkg::xlen;
    // Instructions sent by each test, in the order they run
    localparam int max_inst = 35 + 40 + 13 + 8 + 8 + 25;
    localparam int watchdog_cycles = 200 * max_inst;

    logic            clk;
    logic            arst_n;
    logic [31:0]     inst;
    logic            inst_valid;
    logic [xlen-1:0] result;
    logic [4:0]      result_rd;
    logic            result_valid;
    logic            branch_taken;

    // Reference model of the register file
    logic [xlen-1:0] shadow [0:31];

    int seed = 17473;
    int checks = 0;
    int mismatches = 0;
    int failures = 0;

    exec_core #(.data_width(xlen)) exec_core_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .result       (result),
        .result_rd    (result_rd),
        .result_valid (result_valid),
        .branch_taken (branch_taken)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, riscv_pkg::OPCODE_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscv_pkg::OPCODE_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_pkg::OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, riscv_pkg::OPCODE_LUI};
    endfunction

    function automatic logic [xlen-1:0] sext12(input logic [11:0] imm);
        return {{(xlen-12){imm[11]}}, imm};
    endfunction

    // RV32I integer semantics, alt selects SUB and SRA
    function automatic logic [xlen-1:0] model_alu(input logic [2:0] f3, input logic alt,
                                                  input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
        case (f3)
            riscv_pkg::F3_ADD:  return alt ? a - b : a + b;
            riscv_pkg::F3_SLL:  return a << b[4:0];
            riscv_pkg::F3_SLT:  return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            riscv_pkg::F3_SLTU: return {{(xlen-1){1'b0}}, a < b};
            riscv_pkg::F3_XOR:  return a ^ b;
            riscv_pkg::F3_SR: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> b[4:0]);
                end
                return a >> b[4:0];
            end
            riscv_pkg::F3_OR:   return a | b;
            default:            return a & b;
        endcase
    endfunction

    function automatic logic model_branch(input logic [2:0] f3, input logic [xlen-1:0] a,
                                          input logic [xlen-1:0] b);
        case (f3)
            riscv_pkg::F3_BEQ:  return a == b;
            riscv_pkg::F3_BNE:  return a != b;
            riscv_pkg::F3_BLT:  return $signed(a) < $signed(b);
            riscv_pkg::F3_BGE:  return $signed(a) >= $signed(b);
            riscv_pkg::F3_BLTU: return a < b;
            default:            return a >= b;
        endcase
    endfunction

    task automatic check_result(input logic [riscv_pkg::xlen-1:0] exp,
                                input logic [4:0] exp_rd, input string what);
        checks++;
        if (result !== exp || result_rd !== exp_rd) begin
            mismatches++;
            $display("mismatch at %0t: %s gave %08h rd %0d, expected %08h rd %0d",
                     $time, what, result, result_rd, exp, exp_rd);
        end
    endtask

    task automatic check_branch(input logic exp, input string what);
        checks++;
        if (branch_taken !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s taken %b, expected %b", $time, what,
                     branch_taken, exp);
        end
    endtask

    // Called on a falling edge, returns on the falling edge inside the result pulse
    task automatic issue(input logic [31:0] word);
        int waited;
        waited = 0;
        inst = word;
        inst_valid = 1'b1;
        @(negedge clk);
        inst_valid = 1'b0;
        while (result_valid !== 1'b1 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (result_valid !== 1'b1) begin
            failures++;
            $display("error at %0t: no result_valid for instruction %08h", $time, word);
        end
    endtask

    task automatic run_op(input logic [31:0] word, input logic [xlen-1:0] exp,
                          input string what);
        logic [4:0] rd;
        rd = word[11:7];
        issue(word);
        check_result(exp, rd, what);
        check_branch(1'b0, what);
        if (rd != 5'd0) begin
            shadow[rd] = exp;
        end
    endtask

    task automatic test_addi_fill();
        logic [11:0] imm;
        logic [4:0]  src;
        logic [4:0]  dst;
        for (int r = 1; r < 32; r++) begin
            imm = 12'($random(seed));
            run_op(enc_i(riscv_pkg::OPCODE_OP_IMM, imm, 5'd0, riscv_pkg::F3_ADD, 5'(r)),
                   sext12(imm), "addi from x0");
        end
        // Copy back through ADDI rd, rs, 0
        for (int k = 0; k < 4; k++) begin
            src = 5'($random(seed)) | 5'd1;
            dst = (src == 5'd31) ? 5'd1 : src + 5'd1;
            run_op(enc_i(riscv_pkg::OPCODE_OP_IMM, 12'd0, src, riscv_pkg::F3_ADD, dst),
                   shadow[src], "readback");
        end
    endtask

    task automatic test_reg_ops();
        logic [2:0] f3_tab [0:6] = '{riscv_pkg::F3_ADD, riscv_pkg::F3_ADD, riscv_pkg::F3_AND,
                                     riscv_pkg::F3_OR, riscv_pkg::F3_XOR, riscv_pkg::F3_SLT,
                                     riscv_pkg::F3_SLTU};
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic [2:0] f3;
        logic       alt;
        for (int n = 0; n < 40; n++) begin
            rs1 = 5'($random(seed));
            rs2 = 5'($random(seed));
            rd = 5'($random(seed)) | 5'd1;
            f3 = f3_tab[3'(n % 7)];
            // Second slot is SUB
            alt = (n % 7) == 1;
            run_op(enc_r({1'b0, alt, 5'd0}, rs2, rs1, f3, rd),
                   model_alu(f3, alt, shadow[rs1], shadow[rs2]), "register op");
        end
    endtask

    task automatic test_shifts();
        logic [4:0]  sh;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        alt;
        int          kind;
        // Negative source so SRA has a sign to keep
        run_op(enc_u(20'hF0F0F, 5'd31), 32'hF0F0F000, "lui");
        for (int n = 0; n < 12; n++) begin
            kind = n % 6;
            sh = 5'($random(seed));
            rs1 = (n % 2 == 0) ? 5'd31 : 5'($random(seed));
            rs2 = 5'($random(seed));
            rd = 5'(n + 8);
            f3 = (kind % 3 == 0) ? riscv_pkg::F3_SLL : riscv_pkg::F3_SR;
            alt = (kind % 3) == 2;
            if (kind < 3) begin
                run_op(enc_i(riscv_pkg::OPCODE_OP_IMM, {1'b0, alt, 5'd0, sh}, rs1, f3, rd),
                       model_alu(f3, alt, shadow[rs1], xlen'(sh)), "immediate shift");
            end else begin
                run_op(enc_r({1'b0, alt, 5'd0}, rs2, rs1, f3, rd),
                       model_alu(f3, alt, shadow[rs1], shadow[rs2]), "register shift");
            end
        end
    endtask

    task automatic test_lui();
        logic [19:0] imm;
        logic [4:0]  rd;
        for (int n = 0; n < 6; n++) begin
            imm = 20'($random(seed));
            rd = 5'($random(seed)) | 5'd1;
            run_op(enc_u(imm, rd), {imm, 12'd0}, "lui");
        end
        run_op(enc_u(20'hABCDE, 5'd0), 32'hABCDE000, "lui to x0");
        run_op(enc_r(7'd0, 5'd0, 5'd0, riscv_pkg::F3_ADD, 5'd7), '0, "x0 readback");
    endtask

    task automatic test_mem();
        logic [4:0]  base;
        logic [4:0]  rs2;
        logic [11:0] imm;
        for (int n = 0; n < 8; n++) begin
            base = 5'($random(seed));
            rs2 = 5'($random(seed));
            imm = 12'($random(seed));
            if (n % 2 == 0) begin
                // Load into x0, nothing comes back from memory
                issue(enc_i(riscv_pkg::OPCODE_LOAD, imm, base, 3'b010, 5'd0));
                check_result(shadow[base] + sext12(imm), 5'd0, "load address");
            end else begin
                issue(enc_s(imm, rs2, base));
                check_result(shadow[base] + sext12(imm), imm[4:0], "store address");
            end
        end
    endtask

    task automatic test_branches();
        logic [11:0] val_a [0:2] = '{12'h005, 12'hFFD, 12'h007};
        logic [11:0] val_b [0:2] = '{12'h005, 12'h007, 12'hFFD};
        logic [2:0]  f3_tab [0:5] = '{riscv_pkg::F3_BEQ, riscv_pkg::F3_BNE, riscv_pkg::F3_BLT,
                                      riscv_pkg::F3_BGE, riscv_pkg::F3_BLTU, riscv_pkg::F3_BGEU};
        // Equal, signed less-than, signed greater-than
        for (int p = 0; p < 3; p++) begin
            run_op(enc_i(riscv_pkg::OPCODE_OP_IMM, val_a[2'(p)], 5'd0, riscv_pkg::F3_ADD, 5'd1),
                   sext12(val_a[2'(p)]), "branch operand a");
            run_op(enc_i(riscv_pkg::OPCODE_OP_IMM, val_b[2'(p)], 5'd0, riscv_pkg::F3_ADD, 5'd2),
                   sext12(val_b[2'(p)]), "branch operand b");
            for (int k = 0; k < 6; k++) begin
                // Offset bits fall where rd sits, pointing at x3
                issue(enc_b(f3_tab[3'(k)], 5'd1, 5'd2, 13'h0802));
                check_branch(model_branch(f3_tab[3'(k)], shadow[1], shadow[2]), "branch");
            end
        end
        run_op(enc_r(7'd0, 5'd0, 5'd3, riscv_pkg::F3_ADD, 5'd4), shadow[3], "x3 after branches");
    endtask

    initial begin
        for (int r = 0; r < 32; r++) begin
            shadow[5'(r)] = '0;
        end
        arst_n = 1'b0;
        inst = '0;
        inst_valid = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        test_addi_fill();
        test_reg_ops();
        test_shifts();
        test_lui();
        test_mem();
        test_branches();
        $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
